/* sources.f */
logic/frontend_pkg.sv
logic/ubtb.sv
logic/fetch_pc_gen.sv
logic/fetch_target_queue.sv
logic/block_resolver.sv
logic/frontend_top.sv
test/frontend_tb.sv

/* test/frontend_tb.sv */
`timescale 1ns/1ps

module frontend_tb
    import frontend_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 16;
    // test lengths counted in committed blocks
    localparam int LEN_RESET = 1;
    localparam int LEN_COLD = 1;
    localparam int LEN_REDIRECT = 40;
    localparam int LEN_LEARN = 150;
    localparam int LEN_BACKPRESSURE = 150;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES
        + 200 * (LEN_RESET + LEN_COLD + LEN_REDIRECT + LEN_LEARN + LEN_BACKPRESSURE);

    // one fetched block as the model predicted it
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] next;
        logic [1:0]      scnt;
        logic            hit;
        logic            own;
    } fetched_t;

    logic            clk;
    logic            rst;
    logic            res_valid;
    logic            res_ready;
    res_t            res;
    logic            commit_valid;
    commit_t         commit;
    logic            fetch_valid;
    logic [XLEN-1:0] fetch_pc;

    res_t            prog [logic [XLEN-1:0]];
    ubtb_entry_t     mbtb [UBTB_DEPTH];
    logic [XLEN-1:0] mown [UBTB_DEPTH];
    fetched_t        pend_q [$];
    fetched_t        done_blk;
    res_t            done_res;

    int              pend_cnt;
    int              fail_count = 0;
    int              commit_count;
    int              misp_count;
    int              learned_count;
    int              full_stalls;
    int              reset_edges;
    int              hold_left;
    logic            seen_fetch;
    logic            cold;
    logic            throttle;
    logic            res_on;
    logic            exp_commit;
    logic            exp_misp;
    logic            exp_learned;
    logic [XLEN-1:0] last_fetch_pc;
    logic [XLEN-1:0] exp_fetch_pc;
    logic [XLEN-1:0] exp_start;
    logic [XLEN-1:0] exp_next;

    frontend_top UUT (
        .clk            (clk),
        .rst            (rst),
        .i_res_valid    (res_valid),
        .o_res_ready    (res_ready),
        .i_res          (res),
        .o_commit_valid (commit_valid),
        .o_commit       (commit),
        .o_fetch_valid  (fetch_valid),
        .o_fetch_pc     (fetch_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic void report_mismatch(string name, logic [XLEN-1:0] got,
                                            logic [XLEN-1:0] exp);
        $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        fail_count++;
    endfunction

    function automatic void report_problem(string msg);
        $display("%s", msg);
        fail_count++;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program table and ubtb model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // targets land on a few spots of the same page so the walk loops
    task automatic make_outcome(logic [XLEN-1:0] pc);
        res_t r;
        if (!prog.exists(pc)) begin
            r.fallthru_addr = pc + XLEN'(2 * (1 + $urandom % 8));
            r.taken = (($urandom % 8) < 5);
            r.target_addr = {pc[XLEN-1:12], 12'h000} + XLEN'(32 * ($urandom % 16));
            prog[pc] = r;
        end
    endtask

    function automatic fetched_t predict(logic [XLEN-1:0] pc);
        fetched_t    f;
        ubtb_entry_t e;
        logic [XLEN-1:0] ft;
        logic [XLEN-1:0] tgt;
        e = mbtb[pc[5:1]];
        f.pc = pc;
        f.hit = e.valid && (e.tag == (pc[8:1] ^ pc[16:9]));
        f.scnt = e.scnt;
        ft = f.hit ? pc + XLEN'(e.fallthru_offset) : pc + XLEN'(BLOCK_BYTES);
        tgt = {pc[XLEN-1:12], e.target_low, 1'b0};
        f.next = (f.hit && e.scnt >= 2'd2) ? tgt : ft;
        f.own = f.hit && (mown[pc[5:1]] == pc);
        return f;
    endfunction

    function automatic void train(fetched_t b, res_t r);
        logic [1:0]  base;
        ubtb_entry_t e;
        base = b.hit ? b.scnt : 2'd2;
        e.valid = 1'b1;
        e.tag = b.pc[8:1] ^ b.pc[16:9];
        e.fallthru_offset = OFFSET_W'(r.fallthru_addr - b.pc);
        e.target_low = r.target_addr[11:1];
        if (r.taken) begin
            e.scnt = (base == 2'd3) ? base : base + 2'd1;
        end else begin
            e.scnt = (base == 2'd0) ? base : base - 2'd1;
        end
        mbtb[b.pc[5:1]] = e;
        mown[b.pc[5:1]] = b.pc;
    endfunction

    // fetch lookup first, since an update on this edge is not yet visible
    always @(posedge clk) begin
        if (rst) begin
            pend_q.delete();
            for (int i = 0; i < UBTB_DEPTH; i++) begin
                mbtb[i] = '0;
                mbtb[i].scnt = 2'd3;
            end
            pend_cnt = 0;
            commit_count = 0;
            misp_count = 0;
            learned_count = 0;
            full_stalls = 0;
            reset_edges++;
            seen_fetch = 1'b0;
            cold = 1'b1;
            exp_commit = 1'b0;
            exp_fetch_pc = RESET_PC;
        end else begin
            if (pend_cnt == FTQ_DEPTH && !res_valid) begin
                full_stalls++;
            end
            if (fetch_valid) begin
                pend_q.push_back(predict(fetch_pc));
                exp_fetch_pc = pend_q[$].next;
                // untrained fetch walks forward one block at a time
                last_fetch_pc = seen_fetch ? last_fetch_pc + XLEN'(BLOCK_BYTES) : RESET_PC;
                seen_fetch = 1'b1;
            end
            if (commit_valid) begin
                train(done_blk, done_res);
                commit_count++;
                if (exp_learned) begin
                    learned_count++;
                end
                if (commit.mispredict) begin
                    misp_count++;
                    pend_q.delete();
                    cold = 1'b0;
                    exp_fetch_pc = exp_next;
                end
            end
            exp_commit = 1'b0;
            if (res_valid && res_ready) begin
                done_blk = pend_q.pop_front();
                done_res = prog[done_blk.pc];
                exp_commit = 1'b1;
                exp_start = done_blk.pc;
                exp_next = done_res.taken ? done_res.target_addr : done_res.fallthru_addr;
                exp_misp = (exp_next != done_blk.next);
                exp_learned = done_blk.own && (done_blk.scnt == 2'd3) && done_res.taken;
            end
            pend_cnt = pend_q.size();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_reset_quiet: assert property (@(posedge clk)
        (rst && reset_edges > 0) |-> !(fetch_valid || commit_valid || res_ready))
        else report_problem("a valid or ready output was high during reset");
    a_first_fetch: assert property (@(posedge clk) disable iff (rst)
        (fetch_valid && !seen_fetch) |-> fetch_pc == RESET_PC)
        else report_mismatch("o_fetch_pc", fetch_pc, RESET_PC);
    a_cold_seq: assert property (@(posedge clk) disable iff (rst)
        (fetch_valid && seen_fetch && cold) |-> fetch_pc == last_fetch_pc + BLOCK_BYTES)
        else report_mismatch("o_fetch_pc", fetch_pc, last_fetch_pc + BLOCK_BYTES);
    a_fetch_path: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |-> fetch_pc == exp_fetch_pc)
        else report_mismatch("o_fetch_pc", fetch_pc, exp_fetch_pc);
    a_commit_when: assert property (@(posedge clk) disable iff (rst)
        commit_valid == exp_commit)
        else report_mismatch("o_commit_valid", commit_valid, exp_commit);
    a_commit_start: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit.start_pc == exp_start)
        else report_mismatch("o_commit.start_pc", commit.start_pc, exp_start);
    a_commit_next: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit.next_pc == exp_next)
        else report_mismatch("o_commit.next_pc", commit.next_pc, exp_next);
    a_commit_misp: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit.mispredict == exp_misp)
        else report_mismatch("o_commit.mispredict", commit.mispredict, exp_misp);
    a_learned: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && exp_learned) |-> !commit.mispredict)
        else report_mismatch("o_commit.mispredict", commit.mispredict, 1'b0);
    a_ftq_bound: assert property (@(posedge clk) disable iff (rst)
        pend_cnt <= FTQ_DEPTH)
        else report_problem("more blocks outstanding than the fetch queue holds");
    a_stall_full: assert property (@(posedge clk) disable iff (rst)
        (pend_cnt == FTQ_DEPTH && !res_valid) |-> !fetch_valid)
        else report_problem("a block was fetched while the fetch queue was full");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // backend stimulus and test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_backend();
        logic [XLEN-1:0] pc;
        if (!throttle) begin
            res_on = 1'b1;
        end else if (hold_left == 0) begin
            res_on = !res_on;
            hold_left = res_on ? 1 + $urandom % 4 : 2 + $urandom % 10;
        end else begin
            hold_left--;
        end
        if (res_on && pend_cnt > 0) begin
            pc = pend_q[0].pc;
            make_outcome(pc);
            res = prog[pc];
            res_valid = 1'b1;
        end else begin
            res_valid = 1'b0;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        drive_backend();
    endtask

    task automatic run_commits(int n);
        int target;
        target = commit_count + n;
        while (commit_count < target) begin
            step();
        end
    endtask

    function automatic void report_test(string name, int fails_before);
        $display("test %-22s %s  commits %0d  mispredicts %0d", name,
                 (fail_count == fails_before) ? "passed" : "failed", commit_count, misp_count);
    endfunction

    initial begin
        int fails;
        int misp_base;
        void'($urandom(32'h0c7d374e));
        rst = 1'b1;
        res_valid = 1'b0;
        res = '0;
        throttle = 1'b0;
        res_on = 1'b1;
        hold_left = 0;
        reset_edges = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        fails = fail_count;
        while (!seen_fetch) begin
            step();
        end
        report_test("reset", fails);

        fails = fail_count;
        while (misp_count == 0) begin
            step();
        end
        report_test("cold sequential fetch", fails);

        fails = fail_count;
        misp_base = misp_count;
        run_commits(LEN_REDIRECT);
        if (misp_count - misp_base < 2) begin
            report_problem("redirect test saw fewer than two mispredicted blocks");
        end
        report_test("mispredict redirect", fails);

        fails = fail_count;
        run_commits(LEN_LEARN);
        if (learned_count == 0) begin
            report_problem("no block was committed from a trained taken entry");
        end
        report_test("learned prediction", fails);

        fails = fail_count;
        throttle = 1'b1;
        run_commits(LEN_BACKPRESSURE);
        if (full_stalls == 0) begin
            report_problem("the fetch queue never filled while the backend stalled");
        end
        report_test("back-pressure", fails);

        $display("tests 5  commits %0d  mispredicts %0d  failed checks %0d",
                 commit_count, misp_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles before the tests finished",
                 WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* logic/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top
    import frontend_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            i_res_valid,
    output logic            o_res_ready,
    input  res_t            i_res,
    output logic            o_commit_valid,
    output commit_t         o_commit,
    output logic            o_fetch_valid,
    output logic [XLEN-1:0] o_fetch_pc
);

    logic [XLEN-1:0] lookup_pc;
    ubtb_pred_t      pred;
    logic            blk_valid;
    logic            blk_ready;
    ftq_entry_t      blk;
    logic            head_valid;
    logic            head_ready;
    ftq_entry_t      head;
    logic            update;
    ubtb_update_t    update_info;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    ubtb u_ubtb (
        .clk           (clk),
        .rst           (rst),
        .i_lookup_pc   (lookup_pc),
        .o_pred        (pred),
        .i_update      (update),
        .i_update_info (update_info)
    );

    fetch_pc_gen u_pc_gen (
        .clk           (clk),
        .rst           (rst),
        .o_lookup_pc   (lookup_pc),
        .i_pred        (pred),
        .o_blk_valid   (blk_valid),
        .o_blk         (blk),
        .i_blk_ready   (blk_ready),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc)
    );

    fetch_target_queue u_ftq (
        .clk          (clk),
        .rst          (rst),
        .i_push_valid (blk_valid),
        .o_push_ready (blk_ready),
        .i_push       (blk),
        .o_pop_valid  (head_valid),
        .i_pop_ready  (head_ready),
        .o_pop        (head),
        .i_flush      (redirect)
    );

    block_resolver u_resolver (
        .clk            (clk),
        .rst            (rst),
        .i_blk_valid    (head_valid),
        .o_blk_ready    (head_ready),
        .i_blk          (head),
        .i_res_valid    (i_res_valid),
        .o_res_ready    (o_res_ready),
        .i_res          (i_res),
        .o_update       (update),
        .o_update_info  (update_info),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc),
        .o_commit_valid (o_commit_valid),
        .o_commit       (o_commit)
    );

    // pushes on a flush edge are dropped, so they are not reported
    assign o_fetch_valid = blk_valid & blk_ready & ~redirect;
    assign o_fetch_pc = blk.start_pc;

endmodule

/* logic/block_resolver.sv */
`timescale 1ns/1ps

module block_resolver
    import frontend_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            i_blk_valid,
    output logic            o_blk_ready,
    input  ftq_entry_t      i_blk,
    input  logic            i_res_valid,
    output logic            o_res_ready,
    input  res_t            i_res,
    output logic            o_update,
    output ubtb_update_t    o_update_info,
    output logic            o_redirect,
    output logic [XLEN-1:0] o_redirect_pc,
    output logic            o_commit_valid,
    output commit_t         o_commit
);

    logic            xfer;
    logic [XLEN-1:0] actual_next;
    logic            mispredict;
    logic [1:0]      base_scnt;
    logic [1:0]      new_scnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // block and outcome move together and wait out a pending flush
    assign o_blk_ready = i_res_valid & ~o_redirect;
    assign o_res_ready = i_blk_valid & ~o_redirect;
    assign xfer = i_blk_valid & i_res_valid & ~o_redirect;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outcome check and counter training
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign actual_next = i_res.taken ? i_res.target_addr : i_res.fallthru_addr;
    assign mispredict = (actual_next != i_blk.pred.next_addr);

    always_comb begin
        // a fresh entry starts weakly taken
        base_scnt = i_blk.pred.hit ? i_blk.pred.scnt : SCNT_MISS;
        if (i_res.taken) begin
            new_scnt = (base_scnt == SCNT_MAX) ? SCNT_MAX : base_scnt + 2'd1;
        end else begin
            new_scnt = (base_scnt == SCNT_MIN) ? SCNT_MIN : base_scnt - 2'd1;
        end
    end

    // strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            o_update <= 1'b0;
            o_commit_valid <= 1'b0;
            o_redirect <= 1'b0;
        end else begin
            o_update <= xfer;
            o_commit_valid <= xfer;
            o_redirect <= xfer & mispredict;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (xfer) begin
            o_update_info.pc <= i_blk.start_pc;
            o_update_info.fallthru_addr <= i_res.fallthru_addr;
            o_update_info.target_addr <= i_res.target_addr;
            o_update_info.scnt <= new_scnt;
            o_redirect_pc <= actual_next;
            o_commit.start_pc <= i_blk.start_pc;
            o_commit.next_pc <= actual_next;
            o_commit.mispredict <= mispredict;
        end
    end

endmodule

/* logic/fetch_target_queue.sv */
`timescale 1ns/1ps

module fetch_target_queue
    import frontend_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       i_push_valid,
    output logic       o_push_ready,
    input  ftq_entry_t i_push,
    output logic       o_pop_valid,
    input  logic       i_pop_ready,
    output ftq_entry_t o_pop,
    input  logic       i_flush
);

    ftq_entry_t mem [FTQ_DEPTH];

    logic [FTQ_PTR_W-1:0] wr_ptr;
    logic [FTQ_PTR_W-1:0] rd_ptr;
    logic [FTQ_CNT_W-1:0] count;
    logic                 full;
    logic                 push_fire;
    logic                 pop_fire;

    assign full = (count == FTQ_CNT_W'(FTQ_DEPTH));

    // a full queue still takes a block when the head leaves on the same edge
    assign o_push_ready = ~full | i_pop_ready;
    assign o_pop_valid = (count != '0);
    assign o_pop = mem[rd_ptr];

    assign push_fire = i_push_valid & o_push_ready;
    assign pop_fire = o_pop_valid & i_pop_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            // flush throws away the queue and any push on the same edge
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_fire && !pop_fire) begin
                count <= count + 1'b1;
            end else if (pop_fire && !push_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push_fire && !i_flush) begin
            mem[wr_ptr] <= i_push;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count <= FTQ_CNT_W'(FTQ_DEPTH)
    ) else $error("ftq count overflow: %h", count);

endmodule

/* logic/fetch_pc_gen.sv */
`timescale 1ns/1ps

module fetch_pc_gen
    import frontend_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    output logic [XLEN-1:0] o_lookup_pc,
    input  ubtb_pred_t      i_pred,
    output logic            o_blk_valid,
    output ftq_entry_t      o_blk,
    input  logic            i_blk_ready,
    input  logic            i_redirect,
    input  logic [XLEN-1:0] i_redirect_pc
);

    logic [XLEN-1:0] fetch_pc;
    logic            blk_fire;

    // one block on offer in every cycle out of reset
    assign o_blk_valid = ~rst;
    assign blk_fire = o_blk_valid & i_blk_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch pc
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= RESET_PC;
        end else if (i_redirect) begin
            // backend correction wins over the predicted path
            fetch_pc <= i_redirect_pc;
        end else if (blk_fire) begin
            fetch_pc <= i_pred.next_addr;
        end
    end

    assign o_lookup_pc = fetch_pc;

    always_comb begin
        o_blk.start_pc = fetch_pc;
        o_blk.pred = i_pred;
    end

    // both the ubtb next address and the redirect pc must keep halfword alignment
    a_pc_even: assert property (
        @(posedge clk) disable iff (rst)
        fetch_pc[0] == 1'b0
    ) else $error("fetch pc odd: %h", fetch_pc);

endmodule

/* logic/ubtb.sv */
`timescale 1ns/1ps

module ubtb
    import frontend_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] i_lookup_pc,
    output ubtb_pred_t      o_pred,
    input  logic            i_update,
    input  ubtb_update_t    i_update_info
);

    ubtb_entry_t mem [UBTB_DEPTH];

    logic [UBTB_IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0]      lk_tag;
    ubtb_entry_t           lk_entry;
    logic                  lk_hit;
    logic                  lk_taken;
    logic [XLEN-1:0]       lk_fallthru;
    logic [XLEN-1:0]       lk_target;

    logic [UBTB_IDX_W-1:0] up_idx;
    logic [XLEN-1:0]       up_span;
    ubtb_entry_t           up_entry;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign lk_idx = i_lookup_pc[UBTB_IDX_W:1];
    // fold two byte-ish slices of the pc into the tag
    assign lk_tag = i_lookup_pc[TAG_W:1] ^ i_lookup_pc[2*TAG_W:TAG_W+1];
    assign lk_entry = mem[lk_idx];

    assign lk_hit = lk_entry.valid && (lk_entry.tag == lk_tag);
    assign lk_taken = lk_hit && (lk_entry.scnt >= 2'd2);

    always_comb begin
        if (lk_hit) begin
            lk_fallthru = i_lookup_pc + {{(XLEN-OFFSET_W){1'b0}}, lk_entry.fallthru_offset};
        end else begin
            lk_fallthru = i_lookup_pc + XLEN'(BLOCK_BYTES);
        end
    end

    assign lk_target = {i_lookup_pc[XLEN-1:TARGET_W+1], lk_entry.target_low, 1'b0};

    always_comb begin
        o_pred.hit = lk_hit;
        o_pred.taken = lk_taken;
        o_pred.scnt = lk_entry.scnt;
        o_pred.fallthru_addr = lk_fallthru;
        o_pred.target_addr = lk_target;
        o_pred.next_addr = lk_taken ? lk_target : lk_fallthru;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // training
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign up_idx = i_update_info.pc[UBTB_IDX_W:1];
    assign up_span = i_update_info.fallthru_addr - i_update_info.pc;

    always_comb begin
        up_entry.valid = 1'b1;
        up_entry.tag = i_update_info.pc[TAG_W:1] ^ i_update_info.pc[2*TAG_W:TAG_W+1];
        up_entry.fallthru_offset = up_span[OFFSET_W-1:0];
        up_entry.target_low = i_update_info.target_addr[TARGET_W:1];
        up_entry.scnt = i_update_info.scnt;
    end

    // write lands after the edge, so a same-cycle lookup still reads the old entry
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < UBTB_DEPTH; i++) begin
                mem[i].valid <= 1'b0;
                mem[i].scnt <= SCNT_INIT;
            end
        end else if (i_update) begin
            mem[up_idx] <= up_entry;
        end
    end

    // resolver must hand over a block no longer than the offset field allows
    a_update_span: assert property (
        @(posedge clk) disable iff (rst)
        i_update |-> (up_span >= XLEN'(2)) && (up_span <= XLEN'(BLOCK_BYTES))
    ) else $error("ubtb update span out of range: %h", up_span);

endmodule

/* logic/frontend_pkg.sv */
package frontend_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

    // largest fetch block, also the fallthrough distance on a miss
    localparam int BLOCK_BYTES = 16;
    localparam int OFFSET_W = $clog2(BLOCK_BYTES) + 1;

    localparam int UBTB_DEPTH = 32;
    localparam int UBTB_IDX_W = 5;
    localparam int TAG_W = 8;

    // target keeps pc bits 11..1, upper bits come from the lookup pc
    localparam int TARGET_W = 11;

    localparam int FTQ_DEPTH = 4;
    localparam int FTQ_PTR_W = $clog2(FTQ_DEPTH);
    localparam int FTQ_CNT_W = $clog2(FTQ_DEPTH + 1);

    // counter values
    localparam logic [1:0] SCNT_INIT = 2'd3;
    localparam logic [1:0] SCNT_MISS = 2'd2;
    localparam logic [1:0] SCNT_MAX = 2'd3;
    localparam logic [1:0] SCNT_MIN = 2'd0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ubtb types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                valid;
        logic [TAG_W-1:0]    tag;
        logic [OFFSET_W-1:0] fallthru_offset;
        logic [TARGET_W-1:0] target_low;
        logic [1:0]          scnt;
    } ubtb_entry_t;

    typedef struct packed {
        logic            hit;
        logic            taken;
        logic [1:0]      scnt;
        logic [XLEN-1:0] fallthru_addr;
        logic [XLEN-1:0] target_addr;
        logic [XLEN-1:0] next_addr;
    } ubtb_pred_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] fallthru_addr;
        logic [XLEN-1:0] target_addr;
        logic [1:0]      scnt;
    } ubtb_update_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // queue and backend types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [XLEN-1:0] start_pc;
        ubtb_pred_t      pred;
    } ftq_entry_t;

    // outcome of one block as seen by the backend
    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target_addr;
        logic [XLEN-1:0] fallthru_addr;
    } res_t;

    typedef struct packed {
        logic [XLEN-1:0] start_pc;
        logic [XLEN-1:0] next_pc;
        logic            mispredict;
    } commit_t;

endpackage
